/* include/conv_defines.svh */
/*
 * sizes for the sliding-window pixel cache
 *   image and kernel edge, pixel and address widths
 *   credit count toward the kernel, emitter queue depth
 */
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// pixels per row and rows per image
`define IMG_SIZE 8

// window edge
`define KER_SIZE 3

`define PIX_W 32
`define ADDR_W 6

// kernel buffer depth granted after reset
`define CREDITS 4

`define WQ_DEPTH 3

`endif

/* design/pixel_pkg.sv */
/*
 * pixel data types
 *   pixel_t   one image pixel
 *   window_t  3x3 window, row-major, oldest row and left column first
 *   coord_t   row or column index
 */
`include "conv_defines.svh"

package pixel_pkg;

	typedef logic [`PIX_W-1:0] pixel_t;

	// element 0 is the top-left tap and sits in the upper bits
	typedef pixel_t [0:`KER_SIZE*`KER_SIZE-1] window_t;

	typedef logic [2:0] coord_t;

endpackage

/* design/ctrl_pkg.sv */
/*
 * control types
 *   fetch_state_t  memory read sequencer states
 *   credit_t       credit count toward the kernel
 */
`include "conv_defines.svh"

package ctrl_pkg;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		WAIT_END
	} fetch_state_t;

	// holds 0 to CREDITS
	typedef logic [$clog2(`CREDITS+1)-1:0] credit_t;

endpackage

/* design/win_if.sv */
/*
 * window channel from the line buffer to the emitter
 *   src  drives valid, taps and last
 *   dst  drives stall back to the read side
 */
interface win_if import pixel_pkg::*;;

	logic    valid;
	window_t taps;
	// window ending at the last pixel of the image
	logic    last;
	logic    stall;

	modport src (
		output valid,
		output taps,
		output last,
		input  stall
	);

	modport dst (
		input  valid,
		input  taps,
		input  last,
		output stall
	);

endinterface

/* design/pixel_fetch.sv */
/*
 * memory read sequencer
 *   one read per cycle over the whole image after start
 *   holds the address while the window path is stalled
 */
`include "conv_defines.svh"

module pixel_fetch import ctrl_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  logic              stall,
	output logic              mem_rd,
	output logic [`ADDR_W-1:0] mem_addr
);

	localparam int unsigned LAST_ADDR = `IMG_SIZE * `IMG_SIZE - 1;

	fetch_state_t state;

	// no new read while windows are queued
	assign mem_rd = (state == READ) && !stall;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			mem_addr <= '0;
		end
		else begin
			case (state)
				IDLE: begin
					if (start) begin
						state    <= READ;
						mem_addr <= '0;
					end
				end

				READ: begin
					if (mem_rd) begin
						if (mem_addr == `ADDR_W'(LAST_ADDR)) begin
							state    <= WAIT_END;
							mem_addr <= '0;
						end
						else begin
							mem_addr <= mem_addr + 1'b1;
						end
					end
				end

				// last pixel still on its way from memory
				WAIT_END: begin
					state <= IDLE;
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

/* design/line_buffer.sv */
/*
 * three-row pixel cache
 *   banks 0 and 1 hold the two older rows, bank 2 fills with the current row
 *   banks shift up at each row end
 *   builds one 3x3 window per pixel at row >= 2, column >= 2
 */
`include "conv_defines.svh"

module line_buffer import pixel_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   pix_valid,
	input  pixel_t pix_data,
	win_if.src     win
);

	pixel_t bank0 [`IMG_SIZE];
	pixel_t bank1 [`IMG_SIZE];
	pixel_t bank2 [`IMG_SIZE];

	coord_t row;
	coord_t col;
	coord_t col_l;
	coord_t col_m;
	logic   row_end;
	logic   win_hit;

	// the two columns left of the incoming pixel
	assign col_m = col - coord_t'(1);
	assign col_l = col - coord_t'(2);

	assign row_end = (col == coord_t'(`IMG_SIZE-1));
	assign win_hit = pix_valid && (row >= coord_t'(`KER_SIZE-1)) &&
		(col >= coord_t'(`KER_SIZE-1));

	always_ff @(posedge clk) begin
		if (pix_valid) begin
			bank2[col] <= pix_data;
			if (row_end) begin
				for (int i = 0; i < `IMG_SIZE; i++) begin
					bank0[i] <= bank1[i];
					bank1[i] <= bank2[i];
				end
				// finished row moves up with its last pixel
				bank1[`IMG_SIZE-1] <= pix_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (win_hit) begin
			win.taps <= {
				bank0[col_l], bank0[col_m], bank0[col],
				bank1[col_l], bank1[col_m], bank1[col],
				bank2[col_l], bank2[col_m], pix_data
			};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row       <= '0;
			col       <= '0;
			win.valid <= 1'b0;
			win.last  <= 1'b0;
		end
		else begin
			win.valid <= win_hit;
			win.last  <= win_hit && row_end && (row == coord_t'(`IMG_SIZE-1));
			if (pix_valid) begin
				if (row_end) begin
					col <= '0;
					// wraps for the next image
					if (row == coord_t'(`IMG_SIZE-1))
						row <= '0;
					else
						row <= row + coord_t'(1);
				end
				else begin
					col <= col + coord_t'(1);
				end
			end
		end
	end

endmodule

/* design/window_emitter.sv */
/*
 * window queue toward the kernel
 *   circular queue of windows with their last flags
 *   credit counter, stall back to the read side, done pulse
 */
`include "conv_defines.svh"

module window_emitter import pixel_pkg::*, ctrl_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    credit_return,
	win_if.dst      win,
	output logic    win_valid,
	output window_t win_data,
	output logic    done
);

	localparam int PTR_W = $clog2(`WQ_DEPTH);

	window_t          q_data [`WQ_DEPTH];
	logic             q_last [`WQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	credit_t          credits;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(`WQ_DEPTH-1))
			return '0;
		return p + 1'b1;
	endfunction

	assign push = win.valid;
	// head goes out only against a held credit
	assign pop  = (count != '0) && (credits != '0);

	assign win_valid = pop;
	assign win_data  = q_data[rd_ptr];
	assign win.stall = (count != '0);

	always_ff @(posedge clk) begin
		if (push) begin
			q_data[wr_ptr] <= win.taps;
			q_last[wr_ptr] <= win.last;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			credits <= credit_t'(`CREDITS);
			done    <= 1'b0;
		end
		else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			case ({credit_return, pop})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase

			done <= pop && q_last[rd_ptr];
		end
	end

endmodule

/* design/conv_window_top.sv */
/*
 * sliding-window pixel cache, top level
 *   memory read sequencer, three-row line buffer, window emitter
 */
`include "conv_defines.svh"

module conv_window_top import pixel_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	output logic               mem_rd,
	output logic [`ADDR_W-1:0] mem_addr,
	input  pixel_t             mem_data,
	output logic               win_valid,
	output window_t            win_data,
	input  logic               credit_return,
	output logic               done
);

	logic pix_valid;

	win_if win ();

	// memory answers one cycle after the read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pix_valid <= 1'b0;
		else
			pix_valid <= mem_rd;
	end

	pixel_fetch fetch0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.stall    (win.stall),
		.mem_rd   (mem_rd),
		.mem_addr (mem_addr)
	);

	line_buffer lbuf0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix_valid (pix_valid),
		.pix_data  (mem_data),
		.win       (win.src)
	);

	window_emitter emit0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.credit_return (credit_return),
		.win           (win.dst),
		.win_valid     (win_valid),
		.win_data      (win_data),
		.done          (done)
	);

endmodule

/* sim/conv_window_asserts.sv */
/*
 * emitter assertions, bound into window_emitter
 *   credit count never above its grant
 *   no window leaves without a credit
 *   window queue never overflows
 */
`include "conv_defines.svh"

module conv_window_asserts import ctrl_pkg::*; (
	input logic                       clk,
	input logic                       rst_n,
	input credit_t                    credits,
	input logic                       credit_return,
	input logic                       win_valid,
	input logic                       push,
	input logic                       pop,
	input logic [$clog2(`WQ_DEPTH):0] count
);
	timeunit 1ns;
	timeprecision 100ps;

	// read by the testbench at the end of the run
	int fail_count = 0;

	// credits held as seen from the kernel side of the port
	credit_t held;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			held <= credit_t'(`CREDITS);
		else
			held <= held + credit_t'(credit_return) - credit_t'(win_valid);
	end

	credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= credit_t'(`CREDITS))
	else begin
		fail_count++;
		$error("credit count %0d above grant", credits);
	end

	credit_held: assert property (@(posedge clk) disable iff (!rst_n)
		win_valid |-> held != '0)
	else begin
		fail_count++;
		$error("window sent with no credit held");
	end

	queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= `WQ_DEPTH)
	else begin
		fail_count++;
		$error("queue count %0d above depth", count);
	end

	// a push into a full queue without a pop loses a window
	queue_room: assert property (@(posedge clk) disable iff (!rst_n)
		(push && !pop) |-> count < `WQ_DEPTH)
	else begin
		fail_count++;
		$error("push into full queue");
	end

endmodule

bind window_emitter conv_window_asserts asrt0 (
	.clk           (clk),
	.rst_n         (rst_n),
	.credits       (credits),
	.credit_return (credit_return),
	.win_valid     (win_valid),
	.push          (push),
	.pop           (pop),
	.count         (count)
);

/* sim/conv_window_tb.sv */
/*
 * testbench for the sliding-window pixel cache
 *   one-cycle memory model, credit-returning kernel model, window monitor
 *   directed tests: idle after reset, prompt credits, withheld credits,
 *   back-to-back image with new contents
 */
`include "conv_defines.svh"

module conv_window_tb import pixel_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 20;
	localparam int IMAGES       = 3;
	localparam int IMAGE_CYCLES = 200;
	localparam int SETUP_CYCLES = 20;
	localparam int WATCHDOG_NS  = (IMAGES * IMAGE_CYCLES + SETUP_CYCLES) * CLK_PERIOD;
	localparam int HOLD_CYCLES  = 50;
	localparam int NUM_PIX      = `IMG_SIZE * `IMG_SIZE;
	localparam int NUM_WIN      = (`IMG_SIZE - `KER_SIZE + 1) * (`IMG_SIZE - `KER_SIZE + 1);

	typedef enum {K_PROMPT, K_HOLD, K_TRICKLE} kernel_mode_e;

	logic               clk;
	logic               rst_n;
	logic               start;
	logic               mem_rd;
	logic [`ADDR_W-1:0] mem_addr;
	pixel_t             mem_data;
	logic               win_valid;
	window_t            win_data;
	logic               credit_return;
	logic               done;

	pixel_t             mem [NUM_PIX];
	logic               rd_prev;
	logic [`ADDR_W-1:0] addr_prev;
	kernel_mode_e       kmode;
	int                 owed;
	int                 gap;
	logic [31:0]        img_rng = 32'had9e;
	logic [31:0]        gap_rng = 32'had9e;

	window_t got_q [$];
	int      rd_count;
	int      win_count;
	int      done_count;
	int      win_at_done;
	int      win_errs;
	int      cnt_errs;
	int      other_errs;

	conv_window_top dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.mem_rd        (mem_rd),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.win_valid     (win_valid),
		.win_data      (win_data),
		.credit_return (credit_return),
		.done          (done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// memory answers the read of the previous cycle
	always @(negedge clk) begin
		if (rd_prev)
			mem_data = mem[addr_prev];
		rd_prev   = mem_rd;
		addr_prev = mem_addr;
	end

	// kernel model, returns only credits it has received
	always @(negedge clk) begin
		if (!rst_n) begin
			credit_return = 1'b0;
			owed = 0;
			gap  = 0;
		end
		else begin
			credit_return = 1'b0;
			if (owed > 0 && kmode == K_PROMPT) begin
				credit_return = 1'b1;
				owed--;
			end
			else if (owed > 0 && kmode == K_TRICKLE) begin
				if (gap == 0) begin
					credit_return = 1'b1;
					owed--;
					gap_rng = lcg_next(gap_rng);
					gap = 1 + int'(gap_rng[17:16]) % 3;
				end
				else begin
					gap--;
				end
			end
			if (win_valid)
				owed++;
		end
	end

	always @(negedge clk) begin
		if (mem_rd)
			rd_count++;
		if (win_valid) begin
			win_count++;
			got_q.push_back(win_data);
		end
		if (done) begin
			done_count++;
			win_at_done = win_count;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	task automatic check_window(input window_t expected, input window_t actual,
		input string name);
		if (actual !== expected) begin
			$display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
			win_errs++;
		end
	endtask

	task automatic check_count(input int expected, input int actual, input string name);
		if (actual !== expected) begin
			$display("FAIL %0t %s expected %0d got %0d", $time, name, expected, actual);
			cnt_errs++;
		end
	endtask

	// neighborhood of (r, c) as its bottom-right corner, top-left tap first
	function automatic window_t expected_window(input int r, input int c);
		window_t w;
		for (int k = 0; k < `KER_SIZE * `KER_SIZE; k++)
			w[k] = mem[(r - `KER_SIZE + 1 + k / `KER_SIZE) * `IMG_SIZE +
				(c - `KER_SIZE + 1 + k % `KER_SIZE)];
		return w;
	endfunction

	task automatic fill_image();
		for (int a = 0; a < NUM_PIX; a++) begin
			img_rng = lcg_next(img_rng);
			mem[a] = img_rng ^ pixel_t'(a);
		end
	endtask

	task automatic clear_counts();
		rd_count    = 0;
		win_count   = 0;
		done_count  = 0;
		win_at_done = -1;
		got_q.delete();
	endtask

	task automatic idle_after_reset();
		@(posedge clk);
		clear_counts();
		repeat (10) @(posedge clk);
		check_count(0, rd_count, "mem_rd cycles while idle");
		check_count(0, win_count, "win_valid cycles while idle");
		check_count(0, done_count, "done pulses while idle");
	endtask

	task automatic run_image(input bit withhold);
		int cycles;
		int idx;
		@(posedge clk);
		clear_counts();
		kmode = withhold ? K_HOLD : K_PROMPT;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (withhold) begin
			repeat (HOLD_CYCLES) @(posedge clk);
			check_count(`CREDITS, win_count, "windows with credits withheld");
			kmode = K_TRICKLE;
		end
		cycles = 0;
		while (done_count == 0 && cycles < IMAGE_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (done_count == 0) begin
			$display("no done pulse within %0d cycles of start", IMAGE_CYCLES);
			other_errs++;
		end
		// a second done pulse would show up here
		repeat (2) @(posedge clk);
		check_count(NUM_PIX, rd_count, "mem_rd cycles");
		check_count(NUM_WIN, got_q.size(), "windows");
		check_count(1, done_count, "done pulses");
		check_count(NUM_WIN, win_at_done, "windows before done");
		idx = 0;
		for (int r = `KER_SIZE - 1; r < `IMG_SIZE; r++) begin
			for (int c = `KER_SIZE - 1; c < `IMG_SIZE; c++) begin
				if (idx < got_q.size())
					check_window(expected_window(r, c), got_q[idx],
						$sformatf("win_data[%0d]", idx));
				idx++;
			end
		end
	endtask

	initial begin
		int asrt_errs;
		rst_n         = 1'b0;
		start         = 1'b0;
		mem_data      = '0;
		credit_return = 1'b0;
		rd_prev       = 1'b0;
		addr_prev     = '0;
		kmode         = K_PROMPT;
		win_errs      = 0;
		cnt_errs      = 0;
		other_errs    = 0;
		clear_counts();
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		idle_after_reset();
		fill_image();
		run_image(1'b0);
		fill_image();
		run_image(1'b1);
		// next image right after done, new contents
		fill_image();
		run_image(1'b0);

		@(posedge clk);
		asrt_errs = dut0.emit0.asrt0.fail_count;
		$display("errors: window %0d, count %0d, other %0d, assertion %0d",
			win_errs, cnt_errs, other_errs, asrt_errs);
		if (win_errs + cnt_errs + other_errs + asrt_errs == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+include
design/pixel_pkg.sv
design/ctrl_pkg.sv
design/win_if.sv
design/pixel_fetch.sv
design/line_buffer.sv
design/window_emitter.sv
design/conv_window_top.sv
sim/conv_window_asserts.sv
sim/conv_window_tb.sv
